// ==== common/cache_pkg.sv ====
package cache_pkg;

    // geometry of the two-way cache
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 5;
    localparam int WORDS    = 8;
    localparam int LINE_W   = 256;

    // request opcodes
    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    // cache view of a byte address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    // flat on the memory side, split into fields inside the cache
    typedef union packed {
        logic [31:0]  flat;
        addr_fields_t f;
    } cache_addr_t;

endpackage

// ==== src/req_stage.sv ====
`timescale 1ns/100ps

module req_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          valid,
    input  logic                          op,
    input  cache_pkg::cache_addr_t        addr,
    input  logic [3:0]                    wstrb,
    input  logic [31:0]                   wdata,
    input  logic                          can_accept,
    output logic                          addr_ok,
    output logic                          rd_en,
    output logic [cache_pkg::INDEX_W-1:0] rd_index,
    output logic                          req_valid_q,
    output logic                          op_q,
    output cache_pkg::cache_addr_t        addr_q,
    output logic [3:0]                    wstrb_q,
    output logic [31:0]                   wdata_q
);
    import cache_pkg::*;

    // handshake is combinational in the accept cycle
    assign addr_ok = valid & can_accept;

    // arrays are read in the same cycle as the accept
    assign rd_en    = addr_ok;
    assign rd_index = addr.f.index;

    // stage occupancy, reloaded or emptied whenever lookup frees
    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_valid_q <= 1'b0;
        end else if (can_accept) begin
            req_valid_q <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            op_q    <= op;
            addr_q  <= addr;
            wstrb_q <= wstrb;
            wdata_q <= wdata;
        end
    end

endmodule

// ==== ways/way_store.sv ====
`timescale 1ns/100ps

module way_store (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          rd_en,
    input  logic [cache_pkg::INDEX_W-1:0] rd_index,
    input  logic                          wr_en,
    input  logic [cache_pkg::INDEX_W-1:0] wr_index,
    input  logic [cache_pkg::TAG_W-1:0]   wr_tag,
    input  logic [cache_pkg::LINE_W-1:0]  wr_line,
    input  logic                          wr_dirty,
    output logic [cache_pkg::TAG_W-1:0]   tag,
    output logic                          line_valid,
    output logic                          dirty,
    output logic [cache_pkg::LINE_W-1:0]  line
);
    import cache_pkg::*;

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]  tag_mem  [SETS];
    logic [LINE_W-1:0] line_mem [SETS];
    logic [SETS-1:0]   valid_bits;
    logic [SETS-1:0]   dirty_bits;
    logic              bypass;

    // a refill may land on the set being read in the same cycle
    assign bypass = wr_en & (wr_index == rd_index);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr_en) begin
            valid_bits[wr_index] <= 1'b1;
            dirty_bits[wr_index] <= wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
    end

    // read port holds its value while rd_en is low
    always_ff @(posedge clk) begin
        if (!resetn) begin
            line_valid <= 1'b0;
            dirty      <= 1'b0;
        end else if (rd_en) begin
            line_valid <= bypass | valid_bits[rd_index];
            dirty      <= bypass ? wr_dirty : dirty_bits[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            tag  <= bypass ? wr_tag : tag_mem[rd_index];
            line <= bypass ? wr_line : line_mem[rd_index];
        end
    end

endmodule

// ==== ways/lookup_stage.sv ====
`timescale 1ns/100ps

module lookup_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          req_valid_q,
    input  logic                          op_q,
    input  cache_pkg::cache_addr_t        addr_q,
    input  logic [3:0]                    wstrb_q,
    input  logic [31:0]                   wdata_q,
    input  logic [cache_pkg::TAG_W-1:0]   way0_tag,
    input  logic                          way0_valid,
    input  logic [cache_pkg::LINE_W-1:0]  way0_line,
    input  logic [cache_pkg::TAG_W-1:0]   way1_tag,
    input  logic                          way1_valid,
    input  logic [cache_pkg::LINE_W-1:0]  way1_line,
    input  logic                          victim_way,
    input  logic [cache_pkg::LINE_W-1:0]  refill_line,
    input  logic                          refill_done,
    output logic                          can_accept,
    output logic                          miss,
    output logic                          data_ok,
    output logic [31:0]                   rdata,
    output logic                          wr_en0,
    output logic                          wr_en1,
    output logic [cache_pkg::INDEX_W-1:0] wr_index,
    output logic [cache_pkg::TAG_W-1:0]   wr_tag,
    output logic [cache_pkg::LINE_W-1:0]  wr_line,
    output logic                          wr_dirty
);
    import cache_pkg::*;

    logic                        hit0;
    logic                        hit1;
    logic                        hit;
    logic                        active;
    logic                        done_q;
    logic                        write_hit;
    logic [OFFSET_W-3:0]         word_sel;
    logic [LINE_W-1:0]           src_line;
    logic [LINE_W-1:0]           merged_line;
    logic [31:0]                 old_word;
    logic [31:0]                 new_word;

    assign hit0 = way0_valid & (way0_tag == addr_q.f.tag);
    assign hit1 = way1_valid & (way1_tag == addr_q.f.tag);
    assign hit  = hit0 | hit1;

    // a finished write stays in the registers one more cycle, ignore it
    assign active    = req_valid_q & ~done_q;
    assign write_hit = active & hit & (op_q == OP_WRITE);
    assign miss      = active & ~hit;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= write_hit;
        end
    end

    assign word_sel = addr_q.f.offset[OFFSET_W-1:2];
    assign src_line = refill_done ? refill_line : (hit1 ? way1_line : way0_line);

    // store bytes go over the selected word of the source line
    always_comb begin
        old_word = src_line[word_sel*32 +: 32];
        for (int b = 0; b < 4; b++) begin
            new_word[b*8 +: 8] = wstrb_q[b] ? wdata_q[b*8 +: 8] : old_word[b*8 +: 8];
        end
        merged_line = src_line;
        merged_line[word_sel*32 +: 32] = new_word;
    end

    assign data_ok    = active & (hit | refill_done);
    assign rdata      = old_word;
    assign can_accept = ~active | (hit & (op_q == OP_READ)) | refill_done;

    // write hit goes to the hit way, refill to the victim
    assign wr_en0   = (write_hit & ~hit1) | (refill_done & ~victim_way);
    assign wr_en1   = (write_hit & hit1) | (refill_done & victim_way);
    assign wr_index = addr_q.f.index;
    assign wr_tag   = addr_q.f.tag;
    assign wr_line  = (op_q == OP_WRITE) ? merged_line : src_line;
    assign wr_dirty = (op_q == OP_WRITE);

endmodule

// ==== miss/refill_buffer.sv ====
`timescale 1ns/100ps

module refill_buffer (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic [31:0]                  ret_data,
    output logic [cache_pkg::LINE_W-1:0] line,
    output logic                         line_done
);
    import cache_pkg::*;

    logic [LINE_W-1:0]          buf_q;
    logic [$clog2(WORDS)-1:0]   cnt_q;

    // current beat merged in, so the line is whole on the last beat
    always_comb begin
        line = buf_q;
        if (ret_valid) begin
            line[cnt_q*32 +: 32] = ret_data;
        end
    end

    assign line_done = ret_valid & ret_last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt_q <= '0;
        end else if (line_done) begin
            cnt_q <= '0;
        end else if (ret_valid) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_done) begin
            buf_q <= '0;
        end else if (ret_valid) begin
            buf_q <= line;
        end
    end

endmodule

// ==== miss/miss_fsm.sv ====
`timescale 1ns/100ps

module miss_fsm (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         miss,
    input  cache_pkg::cache_addr_t       addr_q,
    input  logic [cache_pkg::TAG_W-1:0]  way0_tag,
    input  logic                         way0_valid,
    input  logic                         way0_dirty,
    input  logic [cache_pkg::LINE_W-1:0] way0_line,
    input  logic [cache_pkg::TAG_W-1:0]  way1_tag,
    input  logic                         way1_valid,
    input  logic                         way1_dirty,
    input  logic [cache_pkg::LINE_W-1:0] way1_line,
    input  logic                         rd_rdy,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic [31:0]                  ret_data,
    input  logic                         wr_rdy,
    output logic                         victim_way,
    output logic [cache_pkg::LINE_W-1:0] refill_line,
    output logic                         refill_done,
    output logic                         rd_req,
    output logic [31:0]                  rd_addr,
    output logic                         wr_req,
    output logic [31:0]                  wr_addr,
    output logic [cache_pkg::LINE_W-1:0] wr_data
);
    import cache_pkg::*;

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_WB     = 2'd1;
    localparam logic [1:0] ST_REQ    = 2'd2;
    localparam logic [1:0] ST_REFILL = 2'd3;

    logic [1:0]       state_q;
    logic             ptr_q;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    logic             line_done;
    cache_addr_t      rd_a;
    cache_addr_t      wr_a;

    // round-robin choice, stable for the whole miss
    assign victim_way   = ptr_q;
    assign victim_tag   = ptr_q ? way1_tag : way0_tag;
    assign victim_dirty = ptr_q ? (way1_valid & way1_dirty) : (way0_valid & way0_dirty);
    assign wr_data      = ptr_q ? way1_line : way0_line;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
            ptr_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (miss) begin
                        state_q <= victim_dirty ? ST_WB : ST_REQ;
                    end
                end
                ST_WB: begin
                    if (wr_rdy) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (rd_rdy) begin
                        state_q <= ST_REFILL;
                    end
                end
                default: begin
                    if (line_done) begin
                        state_q <= ST_IDLE;
                        ptr_q   <= ~ptr_q;
                    end
                end
            endcase
        end
    end

    // line-aligned addresses of the missing line and of the victim
    always_comb begin
        rd_a          = addr_q;
        rd_a.f.offset = '0;
        wr_a          = rd_a;
        wr_a.f.tag    = victim_tag;
    end

    assign rd_req      = (state_q == ST_REQ);
    assign rd_addr     = rd_a.flat;
    assign wr_req      = (state_q == ST_WB);
    assign wr_addr     = wr_a.flat;
    assign refill_done = line_done & (state_q == ST_REFILL);

    refill_buffer u_refill (
        .clk       (clk),
        .resetn    (resetn),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .line      (refill_line),
        .line_done (line_done)
    );

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/100ps

module cache_top (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         valid,
    input  logic                         op,
    input  cache_pkg::cache_addr_t       addr,
    input  logic [3:0]                   wstrb,
    input  logic [31:0]                  wdata,
    output logic                         addr_ok,
    output logic                         data_ok,
    output logic [31:0]                  rdata,
    output logic                         rd_req,
    output logic [31:0]                  rd_addr,
    input  logic                         rd_rdy,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic [31:0]                  ret_data,
    output logic                         wr_req,
    output logic [31:0]                  wr_addr,
    output logic [cache_pkg::LINE_W-1:0] wr_data,
    input  logic                         wr_rdy
);
    import cache_pkg::*;

    // accept stage to arrays and lookup
    logic               rd_en;
    logic [INDEX_W-1:0] rd_index;
    logic               req_valid_q;
    logic               op_q;
    cache_addr_t        addr_q;
    logic [3:0]         wstrb_q;
    logic [31:0]        wdata_q;
    logic               can_accept;

    // stored contents of the addressed set
    logic [TAG_W-1:0]   way0_tag;
    logic [TAG_W-1:0]   way1_tag;
    logic               way0_valid;
    logic               way1_valid;
    logic               way0_dirty;
    logic               way1_dirty;
    logic [LINE_W-1:0]  way0_line;
    logic [LINE_W-1:0]  way1_line;

    // shared array write port
    logic               wr_en0;
    logic               wr_en1;
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0]   wr_tag;
    logic [LINE_W-1:0]  wr_line;
    logic               wr_dirty;

    // miss handling
    logic               miss;
    logic               victim_way;
    logic [LINE_W-1:0]  refill_line;
    logic               refill_done;

    req_stage u_req (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .op          (op),
        .addr        (addr),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .can_accept  (can_accept),
        .addr_ok     (addr_ok),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .req_valid_q (req_valid_q),
        .op_q        (op_q),
        .addr_q      (addr_q),
        .wstrb_q     (wstrb_q),
        .wdata_q     (wdata_q)
    );

    way_store u_way0 (
        .clk        (clk),
        .resetn     (resetn),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .wr_en      (wr_en0),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line),
        .wr_dirty   (wr_dirty),
        .tag        (way0_tag),
        .line_valid (way0_valid),
        .dirty      (way0_dirty),
        .line       (way0_line)
    );

    way_store u_way1 (
        .clk        (clk),
        .resetn     (resetn),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .wr_en      (wr_en1),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_line    (wr_line),
        .wr_dirty   (wr_dirty),
        .tag        (way1_tag),
        .line_valid (way1_valid),
        .dirty      (way1_dirty),
        .line       (way1_line)
    );

    lookup_stage u_lookup (
        .clk         (clk),
        .resetn      (resetn),
        .req_valid_q (req_valid_q),
        .op_q        (op_q),
        .addr_q      (addr_q),
        .wstrb_q     (wstrb_q),
        .wdata_q     (wdata_q),
        .way0_tag    (way0_tag),
        .way0_valid  (way0_valid),
        .way0_line   (way0_line),
        .way1_tag    (way1_tag),
        .way1_valid  (way1_valid),
        .way1_line   (way1_line),
        .victim_way  (victim_way),
        .refill_line (refill_line),
        .refill_done (refill_done),
        .can_accept  (can_accept),
        .miss        (miss),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .wr_en0      (wr_en0),
        .wr_en1      (wr_en1),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .wr_line     (wr_line),
        .wr_dirty    (wr_dirty)
    );

    miss_fsm u_miss (
        .clk         (clk),
        .resetn      (resetn),
        .miss        (miss),
        .addr_q      (addr_q),
        .way0_tag    (way0_tag),
        .way0_valid  (way0_valid),
        .way0_dirty  (way0_dirty),
        .way0_line   (way0_line),
        .way1_tag    (way1_tag),
        .way1_valid  (way1_valid),
        .way1_dirty  (way1_dirty),
        .way1_line   (way1_line),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .wr_rdy      (wr_rdy),
        .victim_way  (victim_way),
        .refill_line (refill_line),
        .refill_done (refill_done),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
    output logic clk,
    output logic resetn
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held low for the first 10 rising edges
    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
    end

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/100ps

module mem_model (
    input  logic         clk,
    input  logic         stall_en,
    input  logic         rdy_allow,
    input  logic         rd_req,
    input  logic [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [31:0]  ret_data,
    input  logic         wr_req,
    input  logic [31:0]  wr_addr,
    input  logic [255:0] wr_data,
    output logic         wr_rdy,
    output int           wr_count,
    output logic [31:0]  last_wr_addr,
    output logic [255:0] last_wr_line
);

    logic [31:0] words [logic [31:0]];
    int          wait_cnt;
    int          beats_left;
    logic [31:0] beat_addr;
    logic        allow;

    // unwritten words read back as a pattern of their address
    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (words.exists(a)) begin
            return words[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    initial begin
        rd_rdy       = 1'b0;
        wr_rdy       = 1'b0;
        ret_valid    = 1'b0;
        ret_last     = 1'b0;
        ret_data     = '0;
        wr_count     = 0;
        last_wr_addr = '0;
        last_wr_line = '0;
        wait_cnt     = 0;
        beats_left   = 0;
        beat_addr    = '0;
        forever begin
            // sample what the cache showed in the cycle that just ended
            @(posedge clk);
            allow = !stall_en || rdy_allow;
            if (ret_valid) begin
                beats_left--;
                beat_addr += 4;
            end
            if (rd_req && rd_rdy) begin
                beats_left = 8;
                beat_addr  = rd_addr;
                wait_cnt   = 0;
            end else if (wr_req && wr_rdy) begin
                for (int i = 0; i < 8; i++) begin
                    words[wr_addr + 4 * i] = wr_data[i*32 +: 32];
                end
                last_wr_addr = wr_addr;
                last_wr_line = wr_data;
                wr_count++;
                wait_cnt = 0;
            end else if (rd_req || wr_req) begin
                wait_cnt++;
            end
            #1;
            // grant once a request has waited two cycles
            rd_rdy    = (wait_cnt >= 2) && allow;
            wr_rdy    = (wait_cnt >= 2) && allow;
            ret_valid = (beats_left > 0);
            ret_last  = (beats_left == 1);
            ret_data  = ret_valid ? word_at(beat_addr) : '0;
        end
    end

endmodule

// ==== tb/cache_props.sv ====
`timescale 1ns/100ps

module cache_props (
    input logic clk,
    input logic resetn,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy,
    input logic ret_valid,
    input logic refill_done
);

    logic       granted_q;
    logic [3:0] beats_q;

    // a read grant opens the refill window and restarts the beat count
    always_ff @(posedge clk) begin
        if (!resetn) begin
            granted_q <= 1'b0;
            beats_q   <= '0;
        end else if (rd_req && rd_rdy) begin
            granted_q <= 1'b1;
            beats_q   <= '0;
        end else if (refill_done) begin
            granted_q <= 1'b0;
        end else if (ret_valid) begin
            beats_q <= beats_q + 1'b1;
        end
    end

    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    wr_req_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    one_request: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req are high together");

    // done comes with the eighth beat after a granted read
    refill_granted: assert property (@(posedge clk) disable iff (!resetn)
        refill_done |-> (granted_q && beats_q == 4'd7))
        else $error("refill_done without a granted read and eight beats");

endmodule

bind miss_fsm cache_props u_props (
    .clk         (clk),
    .resetn      (resetn),
    .rd_req      (rd_req),
    .rd_rdy      (rd_rdy),
    .wr_req      (wr_req),
    .wr_rdy      (wr_rdy),
    .ret_valid   (ret_valid),
    .refill_done (refill_done)
);

// ==== tb/cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb;
    import cache_pkg::*;

    localparam int N_RANDOM = 300;
    // requests of all tests, for the watchdog budget
    localparam int N_REQS = 1 + 8 + 2 + 4 + N_RANDOM;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                clk;
    logic                resetn;
    logic                valid;
    logic                op;
    cache_addr_t         addr;
    logic [3:0]          wstrb;
    logic [31:0]         wdata;
    logic                addr_ok;
    logic                data_ok;
    logic [31:0]         rdata;
    logic                rd_req;
    logic [31:0]         rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [31:0]         ret_data;
    logic                wr_req;
    logic [31:0]         wr_addr;
    logic [LINE_W-1:0]   wr_data;
    logic                wr_rdy;
    logic                stall_en;
    logic                rdy_allow;
    int                  wr_count;
    logic [31:0]         last_wr_addr;
    logic [LINE_W-1:0]   last_wr_line;

    // expected side, filled on acceptance
    logic [31:0] exp_data [$];
    logic        exp_read [$];
    int          exp_lat  [$];
    int          acc_cyc  [$];
    // observed side, filled on data_ok
    logic [31:0] got_data [$];
    int          got_cyc  [$];
    logic [31:0] ref_mem  [logic [31:0]];
    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] stim_state;
    logic [31:0] stall_state;

    clk_gen   u_clk (.*);
    mem_model u_mem (.*);
    cache_top u_dut (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // one step per bit, first bit ends up on top
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stim_state[0]};
            stim_state = lfsr_next(stim_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] t,
                                              input logic [INDEX_W-1:0] idx,
                                              input logic [2:0] w);
        return {t, idx, w, 2'b00};
    endfunction

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (resetn && data_ok) begin
            got_data.push_back(rdata);
            got_cyc.push_back(cyc);
        end
    end

    // memory grant gating, changes every cycle
    initial begin
        stall_state = 32'd99107;
        rdy_allow   = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rdy_allow   = stall_state[0];
            stall_state = lfsr_next(stall_state);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // called just after an edge; returns just after the accepting edge
    task automatic send(input logic o, input logic [31:0] a, input logic [3:0] s,
                        input logic [31:0] d, input int lat);
        logic [31:0] merged;
        valid     = 1'b1;
        op        = o;
        addr.flat = a;
        wstrb     = s;
        wdata     = d;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        acc_cyc.push_back(cyc);
        exp_lat.push_back(lat);
        exp_read.push_back(o == OP_READ);
        merged = ref_read(a);
        if (o == OP_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    merged[b*8 +: 8] = d[b*8 +: 8];
                end
            end
            ref_mem[a] = merged;
        end
        exp_data.push_back(merged);
        #1;
        valid = 1'b0;
    endtask

    // waits for every data_ok, then compares in order
    task automatic check_responses(input string name);
        while (got_data.size() < exp_data.size()) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        checks++;
        assert (got_data.size() == exp_data.size()) else begin
            errors++;
            $display("%s: got %0d data_ok pulses for %0d requests",
                     name, got_data.size(), exp_data.size());
        end
        for (int i = 0; i < exp_data.size() && i < got_data.size(); i++) begin
            if (exp_read[i]) begin
                check_value({name, " rdata"}, exp_data[i], got_data[i]);
            end
            if (exp_lat[i] >= 0) begin
                check_value({name, " latency"}, exp_lat[i], got_cyc[i] - acc_cyc[i]);
            end
        end
        exp_data.delete();
        exp_read.delete();
        exp_lat.delete();
        acc_cyc.delete();
        got_data.delete();
        got_cyc.delete();
    endtask

    task automatic test_read_miss();
        send(OP_READ, make_addr(20'h00010, 7'd2, 3'd1), 4'h0, 32'h0, -1);
        check_responses("test_read_miss");
    endtask

    task automatic test_read_hits();
        for (int w = 0; w < 8; w++) begin
            send(OP_READ, make_addr(20'h00010, 7'd2, 3'(w)), 4'h0, 32'h0, 1);
        end
        // a read hit frees the stage so accepts come on consecutive cycles
        for (int i = 1; i < 8; i++) begin
            check_value("test_read_hits accept gap", 1, acc_cyc[i] - acc_cyc[i - 1]);
        end
        check_responses("test_read_hits");
    endtask

    task automatic test_write_hit();
        send(OP_WRITE, make_addr(20'h00010, 7'd2, 3'd2), 4'b0101, 32'haabbccdd, 1);
        send(OP_READ, make_addr(20'h00010, 7'd2, 3'd2), 4'h0, 32'h0, 1);
        check_responses("test_write_hit");
    endtask

    task automatic test_evict();
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] victim;
        int          writes_before;
        a0 = make_addr(20'h00100, 7'd5, 3'd3);
        a1 = make_addr(20'h00200, 7'd5, 3'd3);
        a2 = make_addr(20'h00300, 7'd5, 3'd3);
        // round-robin puts a0 in way 1 and a1 in way 0 so a2 evicts a0
        victim = {a0[31:5], 5'b0};
        writes_before = wr_count;
        send(OP_WRITE, a0, 4'hf, 32'h11112222, -1);
        send(OP_WRITE, a1, 4'b1100, 32'h33334444, -1);
        send(OP_READ, a2, 4'h0, 32'h0, -1);
        check_responses("test_evict");
        check_value("test_evict write count", writes_before + 1, wr_count);
        check_value("test_evict write addr", victim, last_wr_addr);
        for (int w = 0; w < 8; w++) begin
            check_value("test_evict line", ref_read(victim + 4 * w), last_wr_line[w*32 +: 32]);
        end
        // word 3 of the evicted line holds the stored word
        send(OP_READ, victim + 12, 4'h0, 32'h0, -1);
        check_responses("test_evict");
    endtask

    task automatic test_random();
        logic        o;
        logic [31:0] a;
        logic [3:0]  s;
        logic [31:0] d;
        stall_en = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            o = 1'(take_bits(1));
            a = make_addr(20'h00400 + 20'(take_bits(2)), 7'd8 + 7'(take_bits(2)),
                          3'(take_bits(3)));
            s = 4'(take_bits(4));
            d = take_bits(32);
            // sometimes leave a bubble
            if (take_bits(1) == 1) begin
                @(posedge clk);
                #1;
            end
            send(o, a, s, d, -1);
        end
        check_responses("test_random");
        stall_en = 1'b0;
    endtask

    initial begin
        repeat (200 * N_REQS + 50) @(posedge clk);
        $display("watchdog expired at cycle %0d with requests still open", cyc);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        valid      = 1'b0;
        op         = OP_READ;
        addr.flat  = '0;
        wstrb      = '0;
        wdata      = '0;
        stall_en   = 1'b0;
        stim_state = 32'd99107;
        wait (resetn === 1'b1);
        @(posedge clk);
        #1;
        test_read_miss();
        test_read_hits();
        test_write_hit();
        test_evict();
        test_random();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/cache_pkg.sv
src/req_stage.sv
ways/way_store.sv
ways/lookup_stage.sv
miss/refill_buffer.sv
miss/miss_fsm.sv
src/cache_top.sv
tb/clk_gen.sv
tb/mem_model.sv
tb/cache_props.sv
tb/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, and grep the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
        -Mdir obj_dir -f vlog.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vcache_tb > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation binary returned an error status"
    exit 1
fi
cat "$LOG"

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
exit 1
